// ==== hdl/aluTypesPkg.sv ====
/*
 * Widths and vector types shared by the execute-stage ALU.
 * Register word, half word and the carry-select chunk types.
 */
package aluTypesPkg;

	// full register width and the width of 32-bit mode
	localparam int dataWidth = 64;
	localparam int halfWidth = 32;

	// carry-select adder partitioning
	localparam int chunkWidth = 16;
	localparam int chunkCount = dataWidth / chunkWidth;

	// operand or result word
	typedef logic [dataWidth-1:0] regWord;

	// low half used in 32-bit mode
	typedef logic [halfWidth-1:0] halfWord;

	// one chunk sum with its carry out on top
	typedef logic [chunkWidth:0] chunkSum;

	// carry into each chunk, chunk 0 in bit 0
	typedef logic [chunkCount-1:0] chunkCarries;

endpackage

// ==== hdl/aluEncodingPkg.sv ====
/*
 * Operation word layout and opcode values for the ALU.
 */
package aluEncodingPkg;

	// operation word
	//   [5]   64-bit mode
	//   [4]   zero extend in 32-bit mode, sign extend when clear
	//   [3:0] opcode
	typedef logic [5:0] opWord;
	typedef logic [3:0] opCode;

	localparam int qwordBit = 5;
	localparam int zextBit = 4;

	// arithmetic
	localparam opCode opAdd = 4'h0;
	localparam opCode opSub = 4'h1;
	localparam opCode opAdc = 4'h2;
	localparam opCode opSbb = 4'h3;

	// logic and test
	localparam opCode opTst = 4'h4;
	localparam opCode opAnd = 4'h5;
	localparam opCode opOr = 4'h6;
	localparam opCode opXor = 4'h7;

	// compares write T only
	localparam opCode opCmpNe = 4'h8;
	localparam opCode opCmpHs = 4'h9;
	localparam opCode opCmpGe = 4'hA;

	// reserved slot, gives zero and keeps T
	localparam opCode opNor = 4'hB;

	localparam opCode opCmpEq = 4'hC;
	localparam opCode opCmpHi = 4'hD;
	localparam opCode opCmpGt = 4'hE;

	// select rs or rt by T
	localparam opCode opCselt = 4'hF;

endpackage

// ==== hdl/carrySelectAdder.sv ====
/*
 * Carry-select add and subtract unit.
 * Each 16-bit chunk is summed for both carry-in values and the
 * chunk carries are chained to pick the right half of each pair.
 */
`timescale 1ns/1ps

module carrySelectAdder (
	input aluTypesPkg::regWord rs,
	input aluTypesPkg::regWord rt,
	input aluEncodingPkg::opWord op,
	input logic srTIn,
	output aluTypesPkg::regWord addSum,
	output aluTypesPkg::regWord subDiff,
	output logic [1:0] addCarry,
	output logic [1:0] subCarry
);

	aluEncodingPkg::opCode code;
	aluTypesPkg::regWord rtInv;

	// per-chunk sums for carry in 0 and carry in 1
	aluTypesPkg::chunkSum addC0 [aluTypesPkg::chunkCount];
	aluTypesPkg::chunkSum addC1 [aluTypesPkg::chunkCount];
	aluTypesPkg::chunkSum subC0 [aluTypesPkg::chunkCount];
	aluTypesPkg::chunkSum subC1 [aluTypesPkg::chunkCount];

	// resolved carry into each chunk
	aluTypesPkg::chunkCarries addCin;
	aluTypesPkg::chunkCarries subCin;

	logic addIn;
	logic subIn;
	logic addTop;
	logic subTop;

	assign code = op[3:0];
	assign rtInv = ~rt;

	// ADC feeds T into the add chain, SBB feeds the borrow as inverted T
	assign addIn = (code == aluEncodingPkg::opAdc) ? srTIn : 1'b0;
	assign subIn = (code == aluEncodingPkg::opSbb) ? ~srTIn : 1'b1;

	for (genvar i = 0; i < aluTypesPkg::chunkCount; i++) begin : chunkGen
		assign addC0[i] = {1'b0, rs[i*aluTypesPkg::chunkWidth +: aluTypesPkg::chunkWidth]} +
			{1'b0, rt[i*aluTypesPkg::chunkWidth +: aluTypesPkg::chunkWidth]};
		assign addC1[i] = {1'b0, rs[i*aluTypesPkg::chunkWidth +: aluTypesPkg::chunkWidth]} +
			{1'b0, rt[i*aluTypesPkg::chunkWidth +: aluTypesPkg::chunkWidth]} + 1'b1;
		// subtract as rs + ~rt + carry
		assign subC0[i] = {1'b0, rs[i*aluTypesPkg::chunkWidth +: aluTypesPkg::chunkWidth]} +
			{1'b0, rtInv[i*aluTypesPkg::chunkWidth +: aluTypesPkg::chunkWidth]};
		assign subC1[i] = {1'b0, rs[i*aluTypesPkg::chunkWidth +: aluTypesPkg::chunkWidth]} +
			{1'b0, rtInv[i*aluTypesPkg::chunkWidth +: aluTypesPkg::chunkWidth]} + 1'b1;
	end

	// carry chain, each stage picks the carry out of the previous chunk
	always_comb begin
		addCin[0] = addIn;
		subCin[0] = subIn;
		for (int i = 1; i < aluTypesPkg::chunkCount; i++) begin
			addCin[i] = addCin[i-1] ? addC1[i-1][aluTypesPkg::chunkWidth] :
				addC0[i-1][aluTypesPkg::chunkWidth];
			subCin[i] = subCin[i-1] ? subC1[i-1][aluTypesPkg::chunkWidth] :
				subC0[i-1][aluTypesPkg::chunkWidth];
		end
	end

	// chunk result selection
	always_comb begin
		for (int i = 0; i < aluTypesPkg::chunkCount; i++) begin
			addSum[i*aluTypesPkg::chunkWidth +: aluTypesPkg::chunkWidth] = addCin[i] ?
				addC1[i][aluTypesPkg::chunkWidth-1:0] : addC0[i][aluTypesPkg::chunkWidth-1:0];
			subDiff[i*aluTypesPkg::chunkWidth +: aluTypesPkg::chunkWidth] = subCin[i] ?
				subC1[i][aluTypesPkg::chunkWidth-1:0] : subC0[i][aluTypesPkg::chunkWidth-1:0];
		end
	end

	// carry out of the top chunk
	assign addTop = addCin[aluTypesPkg::chunkCount-1] ?
		addC1[aluTypesPkg::chunkCount-1][aluTypesPkg::chunkWidth] :
		addC0[aluTypesPkg::chunkCount-1][aluTypesPkg::chunkWidth];
	assign subTop = subCin[aluTypesPkg::chunkCount-1] ?
		subC1[aluTypesPkg::chunkCount-1][aluTypesPkg::chunkWidth] :
		subC0[aluTypesPkg::chunkCount-1][aluTypesPkg::chunkWidth];

	// bit 0 is the carry out of bit 31, i.e. the carry into the upper half
	assign addCarry = {addTop, addCin[aluTypesPkg::halfWidth / aluTypesPkg::chunkWidth]};
	assign subCarry = {subTop, subCin[aluTypesPkg::halfWidth / aluTypesPkg::chunkWidth]};

endmodule

// ==== hdl/compareFlags.sv ====
/*
 * Compare and test predicates.
 * Zero, carry, sign and overflow of rs - rt at the mode width,
 * the zero test of rs & rt, and the opcode to T mapping.
 */
`timescale 1ns/1ps

module compareFlags (
	input aluTypesPkg::regWord rs,
	input aluTypesPkg::regWord rt,
	input aluEncodingPkg::opWord op,
	input aluTypesPkg::regWord subDiff,
	input logic [1:0] subCarry,
	output logic predT
);

	aluEncodingPkg::opCode code;
	logic qword;

	logic zeroLo;
	logic zeroHi;
	logic zeroFlag;
	logic carryFlag;
	logic signFlag;
	logic overflowFlag;
	logic rsSign;
	logic rtSign;

	aluTypesPkg::halfWord andLo;
	aluTypesPkg::halfWord andHi;
	logic andZero;

	assign code = op[3:0];
	assign qword = op[aluEncodingPkg::qwordBit];

	// difference flags, upper half only counts in 64-bit mode
	assign zeroLo = (subDiff[aluTypesPkg::halfWidth-1:0] == '0);
	assign zeroHi = (subDiff[aluTypesPkg::dataWidth-1:aluTypesPkg::halfWidth] == '0);
	assign zeroFlag = qword ? (zeroLo && zeroHi) : zeroLo;

	// carry set means no borrow, rs >= rt unsigned
	assign carryFlag = qword ? subCarry[1] : subCarry[0];

	assign signFlag = qword ? subDiff[aluTypesPkg::dataWidth-1] :
		subDiff[aluTypesPkg::halfWidth-1];
	assign rsSign = qword ? rs[aluTypesPkg::dataWidth-1] : rs[aluTypesPkg::halfWidth-1];
	assign rtSign = qword ? rt[aluTypesPkg::dataWidth-1] : rt[aluTypesPkg::halfWidth-1];

	// signs differ and the difference took the sign of rt
	assign overflowFlag = (rsSign ^ rtSign) & (signFlag ^ rsSign);

	// TST
	assign andLo = rs[aluTypesPkg::halfWidth-1:0] & rt[aluTypesPkg::halfWidth-1:0];
	assign andHi = rs[aluTypesPkg::dataWidth-1:aluTypesPkg::halfWidth] &
		rt[aluTypesPkg::dataWidth-1:aluTypesPkg::halfWidth];
	assign andZero = qword ? ((andLo == '0) && (andHi == '0)) : (andLo == '0);

	always_comb begin
		case (code)
			aluEncodingPkg::opCmpNe: predT = !zeroFlag;
			aluEncodingPkg::opCmpHs: predT = carryFlag;
			aluEncodingPkg::opCmpGe: predT = (signFlag == overflowFlag);
			aluEncodingPkg::opCmpEq: predT = zeroFlag;
			aluEncodingPkg::opCmpHi: predT = carryFlag && !zeroFlag;
			aluEncodingPkg::opCmpGt: predT = !zeroFlag && (signFlag == overflowFlag);
			aluEncodingPkg::opTst: predT = andZero;
			// not looked at for other opcodes
			default: predT = 1'b0;
		endcase
	end

endmodule

// ==== hdl/aluResultStage.sv ====
/*
 * Result selection and the ALU pipeline register.
 * Value mux, 32-bit mode extension, T update, and the output
 * register that holds while hold is high.
 */
`timescale 1ns/1ps

module aluResultStage (
	input logic clock,
	input logic arstN,
	input logic hold,
	input aluTypesPkg::regWord rs,
	input aluTypesPkg::regWord rt,
	input aluEncodingPkg::opWord op,
	input logic srTIn,
	input aluTypesPkg::regWord addSum,
	input aluTypesPkg::regWord subDiff,
	input logic [1:0] addCarry,
	input logic [1:0] subCarry,
	input logic predT,
	output aluTypesPkg::regWord result,
	output logic srTOut
);

	aluEncodingPkg::opCode code;
	logic qword;
	logic zext;

	aluTypesPkg::regWord rawValue;
	aluTypesPkg::halfWord lowValue;
	aluTypesPkg::regWord nextValue;
	logic signFill;

	logic addCarryMode;
	logic subCarryMode;
	logic nextT;

	assign code = op[3:0];
	assign qword = op[aluEncodingPkg::qwordBit];
	assign zext = op[aluEncodingPkg::zextBit];

	always_comb begin
		rawValue = '0;
		case (code)
			aluEncodingPkg::opAdd,
			aluEncodingPkg::opAdc: rawValue = addSum;
			aluEncodingPkg::opSub,
			aluEncodingPkg::opSbb: rawValue = subDiff;
			aluEncodingPkg::opAnd: rawValue = rs & rt;
			aluEncodingPkg::opOr: rawValue = rs | rt;
			aluEncodingPkg::opXor: rawValue = rs ^ rt;
			aluEncodingPkg::opCselt: rawValue = srTIn ? rs : rt;
			// compares, TST and the reserved slot give zero
			aluEncodingPkg::opTst,
			aluEncodingPkg::opCmpNe,
			aluEncodingPkg::opCmpHs,
			aluEncodingPkg::opCmpGe,
			aluEncodingPkg::opNor,
			aluEncodingPkg::opCmpEq,
			aluEncodingPkg::opCmpHi,
			aluEncodingPkg::opCmpGt: rawValue = '0;
			default: rawValue = '0;
		endcase
	end

	// 32-bit mode extends the low half
	assign lowValue = rawValue[aluTypesPkg::halfWidth-1:0];
	assign signFill = lowValue[aluTypesPkg::halfWidth-1] & ~zext;
	assign nextValue = qword ? rawValue : {{aluTypesPkg::halfWidth{signFill}}, lowValue};

	// carry out at the mode width
	assign addCarryMode = qword ? addCarry[1] : addCarry[0];
	assign subCarryMode = qword ? subCarry[1] : subCarry[0];

	always_comb begin
		case (code)
			aluEncodingPkg::opTst,
			aluEncodingPkg::opCmpNe,
			aluEncodingPkg::opCmpHs,
			aluEncodingPkg::opCmpGe,
			aluEncodingPkg::opCmpEq,
			aluEncodingPkg::opCmpHi,
			aluEncodingPkg::opCmpGt: nextT = predT;
			aluEncodingPkg::opAdc: nextT = addCarryMode;
			// T is the borrow for SBB
			aluEncodingPkg::opSbb: nextT = ~subCarryMode;
			default: nextT = srTIn;
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			result <= '0;
			srTOut <= 1'b0;
		end else if (!hold) begin
			result <= nextValue;
			srTOut <= nextT;
		end
	end

endmodule

// ==== hdl/execAlu.sv ====
/*
 * Integer ALU of the execute stage.
 * Adder, compare flags and the registered result stage.
 */
`timescale 1ns/1ps

module execAlu (
	input logic clock,
	input logic arstN,
	input aluTypesPkg::regWord rs,
	input aluTypesPkg::regWord rt,
	input aluEncodingPkg::opWord op,
	input logic hold,
	input logic srTIn,
	output aluTypesPkg::regWord result,
	output logic srTOut
);

	aluTypesPkg::regWord addSum;
	aluTypesPkg::regWord subDiff;
	logic [1:0] addCarry;
	logic [1:0] subCarry;
	logic predT;

	carrySelectAdder adder (
		.rs(rs),
		.rt(rt),
		.op(op),
		.srTIn(srTIn),
		.addSum(addSum),
		.subDiff(subDiff),
		.addCarry(addCarry),
		.subCarry(subCarry)
	);

	// compares run on the subtract chain
	compareFlags flags (
		.rs(rs),
		.rt(rt),
		.op(op),
		.subDiff(subDiff),
		.subCarry(subCarry),
		.predT(predT)
	);

	aluResultStage resultStage (
		.clock(clock),
		.arstN(arstN),
		.hold(hold),
		.rs(rs),
		.rt(rt),
		.op(op),
		.srTIn(srTIn),
		.addSum(addSum),
		.subDiff(subDiff),
		.addCarry(addCarry),
		.subCarry(subCarry),
		.predT(predT),
		.result(result),
		.srTOut(srTOut)
	);

endmodule

// ==== include/aluTbChecks.svh ====
/*
 * Compare tasks for the ALU testbench, typed to the DUT types,
 * and the common failure exit.
 */
`ifndef ALU_TB_CHECKS_SVH
`define ALU_TB_CHECKS_SVH

	// ends the run with the fail message and a nonzero exit
	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("TB FAILED");
		$fatal(1, "%s", reason);
	endtask

	// full register word, result port
	task automatic checkRegWord(
		input string testName,
		input aluTypesPkg::regWord expected,
		input aluTypesPkg::regWord actual
	);
		if (expected !== actual) begin
			$display("CHECK FAILED %s expected %h actual %h", testName, expected, actual);
			failRun("result value mismatch");
		end
	endtask

	// single status bit, the T output
	task automatic checkBit(
		input string testName,
		input logic expected,
		input logic actual
	);
		if (expected !== actual) begin
			$display("CHECK FAILED %s expected %b actual %b", testName, expected, actual);
			failRun("status bit mismatch");
		end
	endtask

`endif

// ==== bench/aluTb.sv ====
/*
 * Testbench for the execute-stage ALU.
 * Clock, reset, watchdog, LCG stimulus, a behavioral model
 * and the directed test tasks.
 */
`timescale 1ns/1ps

module aluTb;

	localparam int clockPeriod = 40;
	localparam int resetCycles = 8;
	localparam int edgeCount = 8;
	localparam int randomPairs = 16;
	localparam int codeCount = 16;
	localparam int opsPerPair = 6;
	localparam int holdCycles = 6;
	localparam int marginCycles = 100;
	localparam int testCycles = resetCycles + holdCycles +
		codeCount * (edgeCount * edgeCount + randomPairs) * opsPerPair;

	logic clock;
	logic arstN;
	aluTypesPkg::regWord rs;
	aluTypesPkg::regWord rt;
	aluEncodingPkg::opWord op;
	logic hold;
	logic srTIn;
	aluTypesPkg::regWord result;
	logic srTOut;
	logic [31:0] lcgState;

	// zero, ones and the sign boundaries at both widths
	aluTypesPkg::regWord edgeValues [edgeCount] = '{
		64'h0000000000000000, 64'h0000000000000001,
		64'hffffffffffffffff, 64'h7fffffffffffffff,
		64'h8000000000000000, 64'h000000007fffffff,
		64'h0000000080000000, 64'hffffffff00000000
	};

	execAlu DUT (
		.clock(clock),
		.arstN(arstN),
		.rs(rs),
		.rt(rt),
		.op(op),
		.hold(hold),
		.srTIn(srTIn),
		.result(result),
		.srTOut(srTOut)
	);

	`include "aluTbChecks.svh"

	initial begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	initial begin : watchdog
		#((testCycles + marginCycles) * clockPeriod);
		$display("timeout, the run hung past %0d cycles", testCycles + marginCycles);
		failRun("watchdog expired before the tests finished");
	end

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic aluTypesPkg::regWord randomWord();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = nextRandom();
		lo = nextRandom();
		return {hi, lo};
	endfunction

	// expected value and T from the operation rules
	function automatic void modelAlu(
		input aluEncodingPkg::opWord opVal,
		input aluTypesPkg::regWord aVal,
		input aluTypesPkg::regWord bVal,
		input logic tIn,
		output aluTypesPkg::regWord value,
		output logic tOut
	);
		logic qword;
		aluEncodingPkg::opCode code;
		aluTypesPkg::regWord a;
		aluTypesPkg::regWord b;
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic [65:0] wide;
		logic carryIn;
		aluTypesPkg::regWord raw;
		qword = opVal[aluEncodingPkg::qwordBit];
		code = opVal[3:0];
		// unsigned and signed operand views at the mode width
		a = qword ? aVal : {32'h0, aVal[31:0]};
		b = qword ? bVal : {32'h0, bVal[31:0]};
		sa = qword ? aVal : {{32{aVal[31]}}, aVal[31:0]};
		sb = qword ? bVal : {{32{bVal[31]}}, bVal[31:0]};
		raw = '0;
		tOut = tIn;
		case (code)
			aluEncodingPkg::opAdd, aluEncodingPkg::opAdc: begin
				carryIn = (code == aluEncodingPkg::opAdc) ? tIn : 1'b0;
				wide = {2'b0, a} + {2'b0, b} + {65'b0, carryIn};
				raw = wide[63:0];
				if (code == aluEncodingPkg::opAdc)
					tOut = qword ? wide[64] : wide[32];
			end
			aluEncodingPkg::opSub, aluEncodingPkg::opSbb: begin
				// T is the borrow in and the borrow out
				carryIn = (code == aluEncodingPkg::opSbb) ? tIn : 1'b0;
				raw = a - b - {63'b0, carryIn};
				if (code == aluEncodingPkg::opSbb)
					tOut = ({2'b0, a} < ({2'b0, b} + {65'b0, carryIn}));
			end
			aluEncodingPkg::opAnd: raw = aVal & bVal;
			aluEncodingPkg::opOr: raw = aVal | bVal;
			aluEncodingPkg::opXor: raw = aVal ^ bVal;
			aluEncodingPkg::opCselt: raw = tIn ? aVal : bVal;
			aluEncodingPkg::opTst: tOut = ((a & b) == '0);
			aluEncodingPkg::opCmpNe: tOut = (a != b);
			aluEncodingPkg::opCmpHs: tOut = (a >= b);
			aluEncodingPkg::opCmpGe: tOut = (sa >= sb);
			aluEncodingPkg::opCmpEq: tOut = (a == b);
			aluEncodingPkg::opCmpHi: tOut = (a > b);
			aluEncodingPkg::opCmpGt: tOut = (sa > sb);
			default: raw = '0;
		endcase
		if (!qword)
			raw = opVal[aluEncodingPkg::zextBit] ? {32'h0, raw[31:0]} :
				{{32{raw[31]}}, raw[31:0]};
		value = raw;
	endfunction

	// starts and ends on a falling edge
	task automatic runOp(
		input string name,
		input aluEncodingPkg::opWord opVal,
		input aluTypesPkg::regWord aVal,
		input aluTypesPkg::regWord bVal,
		input logic tIn
	);
		aluTypesPkg::regWord expValue;
		logic expT;
		string tag;
		modelAlu(opVal, aVal, bVal, tIn, expValue, expT);
		tag = $sformatf("%s op=%h rs=%h rt=%h t=%b", name, opVal, aVal, bVal, tIn);
		rs = aVal;
		rt = bVal;
		op = opVal;
		srTIn = tIn;
		@(posedge clock);
		@(negedge clock);
		checkRegWord(tag, expValue, result);
		checkBit(tag, expT, srTOut);
	endtask

	// 64-bit and both 32-bit extensions with T 0 and 1
	task automatic modeSweep(
		input string name,
		input aluEncodingPkg::opCode code,
		input aluTypesPkg::regWord aVal,
		input aluTypesPkg::regWord bVal
	);
		logic [1:0] modeBits;
		for (int m = 0; m < 3; m++) begin
			modeBits = (m == 0) ? 2'b10 : ((m == 1) ? 2'b00 : 2'b01);
			for (int t = 0; t < 2; t++)
				runOp(name, {modeBits, code}, aVal, bVal, (t == 1));
		end
	endtask

	task automatic sweepCode(input string name, input aluEncodingPkg::opCode code);
		aluTypesPkg::regWord a;
		aluTypesPkg::regWord b;
		for (int i = 0; i < edgeCount; i++)
			for (int j = 0; j < edgeCount; j++)
				modeSweep(name, code, edgeValues[i], edgeValues[j]);
		for (int k = 0; k < randomPairs; k++) begin
			a = randomWord();
			b = randomWord();
			modeSweep(name, code, a, b);
		end
	endtask

	task automatic resetState();
		// nonzero inputs while in reset
		rs = '1;
		rt = '1;
		op = {2'b10, aluEncodingPkg::opAdc};
		srTIn = 1'b1;
		repeat (resetCycles) @(negedge clock);
		checkRegWord("reset value", '0, result);
		checkBit("reset T", 1'b0, srTOut);
		arstN = 1'b1;
	endtask

	task automatic arithOps();
		sweepCode("add", aluEncodingPkg::opAdd);
		sweepCode("sub", aluEncodingPkg::opSub);
		sweepCode("adc", aluEncodingPkg::opAdc);
		sweepCode("sbb", aluEncodingPkg::opSbb);
	endtask

	task automatic logicOps();
		sweepCode("and", aluEncodingPkg::opAnd);
		sweepCode("or", aluEncodingPkg::opOr);
		sweepCode("xor", aluEncodingPkg::opXor);
		sweepCode("cselt", aluEncodingPkg::opCselt);
		sweepCode("reserved", aluEncodingPkg::opNor);
	endtask

	task automatic compareOps();
		sweepCode("tst", aluEncodingPkg::opTst);
		sweepCode("cmpne", aluEncodingPkg::opCmpNe);
		sweepCode("cmphs", aluEncodingPkg::opCmpHs);
		sweepCode("cmpge", aluEncodingPkg::opCmpGe);
		sweepCode("cmpeq", aluEncodingPkg::opCmpEq);
		sweepCode("cmphi", aluEncodingPkg::opCmpHi);
		sweepCode("cmpgt", aluEncodingPkg::opCmpGt);
	endtask

	task automatic holdStall();
		// 5 + 7 with T set so T passes through ADD
		runOp("hold load", {2'b10, aluEncodingPkg::opAdd}, 64'd5, 64'd7, 1'b1);
		hold = 1'b1;
		rs = randomWord();
		rt = randomWord();
		op = {2'b10, aluEncodingPkg::opXor};
		srTIn = 1'b0;
		repeat (3) begin
			@(posedge clock);
			@(negedge clock);
			checkRegWord("hold value", 64'd12, result);
			checkBit("hold T", 1'b1, srTOut);
		end
		hold = 1'b0;
		runOp("hold release", {2'b10, aluEncodingPkg::opSub}, 64'd100, 64'd1, 1'b0);
	endtask

	initial begin
		arstN = 1'b0;
		hold = 1'b0;
		rs = '0;
		rt = '0;
		op = '0;
		srTIn = 1'b0;
		lcgState = 32'd22760;
		resetState();
		arithOps();
		logicOps();
		compareOps();
		holdStall();
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+include
hdl/aluTypesPkg.sv
hdl/aluEncodingPkg.sv
hdl/carrySelectAdder.sv
hdl/compareFlags.sv
hdl/aluResultStage.sv
hdl/execAlu.sv
bench/aluTb.sv

// ==== Makefile ====
# Verilator build for the execute-stage ALU testbench

TOP := aluTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f src.f \
		-Mdir obj_dir -o aluTbSim
	./obj_dir/aluTbSim

clean:
	rm -rf obj_dir
